/* logic/lsu_pkg.sv */
/*
 * LSU shared definitions
 * Data and register index widths, vector types and the load/store
 * operation codes used between the decoder, the LSU and the data RAM
 */

package lsu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int DATA_WIDTH     = 32;             // Data word and address width
  localparam int REG_ADDR_WIDTH = 5;              // x0..x31
  localparam int BYTE_LANES     = DATA_WIDTH / 8;
  localparam int LSU_CTRL_WIDTH = 4;              // {store, funct3}

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////
  typedef logic [DATA_WIDTH-1:0]     data_t;      // Data word or byte address
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;  // Destination register
  typedef logic [BYTE_LANES-1:0]     byte_en_t;   // One enable per byte lane
  typedef logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_t;  // Operation code

  //////////////////////////////////////////////////
  // Operation codes
  //////////////////////////////////////////////////
  // Low three bits follow the RISC-V funct3 field
  // Top bit set marks a store

  // Signed loads
  localparam lsu_ctrl_t LSU_LOAD_BYTE        = 4'b0000;
  localparam lsu_ctrl_t LSU_LOAD_HALF_WORD   = 4'b0001;
  localparam lsu_ctrl_t LSU_LOAD_WORD        = 4'b0010;

  // Unsigned loads
  localparam lsu_ctrl_t LSU_LOAD_BYTE_U      = 4'b0100;
  localparam lsu_ctrl_t LSU_LOAD_HALF_WORD_U = 4'b0101;

  // Stores
  localparam lsu_ctrl_t LSU_STORE_BYTE       = 4'b1000;
  localparam lsu_ctrl_t LSU_STORE_HALF_WORD  = 4'b1001;
  localparam lsu_ctrl_t LSU_STORE_WORD       = 4'b1010;

endpackage : lsu_pkg

/* logic/lsu_store_align.sv */
/*
 * Store aligner
 * Steers store bytes and halfwords onto the addressed byte lanes
 * and builds the matching RAM byte write enables
 */

module lsu_store_align (
  input  lsu_pkg::lsu_ctrl_t ctrl_i,      // Operation code
  input  logic [1:0]         byte_off_i,  // Address bits 1:0
  input  lsu_pkg::data_t     wdata_i,     // Store data, right-aligned
  output lsu_pkg::byte_en_t  we_o,        // Byte lane enables
  output lsu_pkg::data_t     wdata_o      // Lane-steered store data
);
  import lsu_pkg::*;

  logic [7:0]  st_byte;   // Low byte of the store data
  logic [15:0] st_half;   // Low halfword of the store data

  assign st_byte = wdata_i[7:0];
  assign st_half = wdata_i[15:0];

  //////////////////////////////////////////////////
  // Lane steering
  //////////////////////////////////////////////////
  always_comb begin
    we_o    = '0;                         // Loads and unknown codes write nothing
    wdata_o = '0;
    case (ctrl_i)
      LSU_STORE_BYTE: begin
        // One lane, picked by both offset bits
        we_o    = byte_en_t'(1) << byte_off_i;
        wdata_o = data_t'(st_byte) << {byte_off_i, 3'b000};
      end
      LSU_STORE_HALF_WORD: begin
        // Bit 0 ignored, no misalignment handling
        if (byte_off_i[1]) begin
          we_o    = 4'b1100;              // Upper half
          wdata_o = {st_half, 16'h0000};
        end else begin
          we_o    = 4'b0011;              // Lower half
          wdata_o = {16'h0000, st_half};
        end
      end
      LSU_STORE_WORD: begin
        we_o    = '1;                     // Offset ignored
        wdata_o = wdata_i;
      end
      default: begin
        we_o    = '0;
        wdata_o = '0;
      end
    endcase
  end

endmodule : lsu_store_align

/* logic/lsu_load_align.sv */
/*
 * Load aligner
 * Picks the addressed byte or halfword out of a RAM word and
 * zero- or sign-extends it to a full register value
 */

module lsu_load_align (
  input  lsu_pkg::lsu_ctrl_t ctrl_i,      // Load operation code
  input  logic [1:0]         byte_off_i,  // Address bits 1:0 of the load
  input  lsu_pkg::data_t     word_i,      // Word as read from RAM
  output lsu_pkg::data_t     data_o       // Register file value
);
  import lsu_pkg::*;

  logic [7:0]  sel_byte;  // Addressed byte
  logic [15:0] sel_half;  // Addressed halfword

  //////////////////////////////////////////////////
  // Lane select
  //////////////////////////////////////////////////
  always_comb begin
    case (byte_off_i)
      2'd0:    sel_byte = word_i[7:0];
      2'd1:    sel_byte = word_i[15:8];
      2'd2:    sel_byte = word_i[23:16];
      default: sel_byte = word_i[31:24];
    endcase
  end

  // Halfwords only look at bit 1
  assign sel_half = byte_off_i[1] ? word_i[31:16] : word_i[15:0];

  //////////////////////////////////////////////////
  // Extension
  //////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i)
      LSU_LOAD_BYTE: begin
        // Replicate bit 7 into the upper bits
        data_o = {{(DATA_WIDTH-8){sel_byte[7]}}, sel_byte};
      end
      LSU_LOAD_BYTE_U: begin
        data_o = {{(DATA_WIDTH-8){1'b0}}, sel_byte};
      end
      LSU_LOAD_HALF_WORD: begin
        // Replicate bit 15 into the upper bits
        data_o = {{(DATA_WIDTH-16){sel_half[15]}}, sel_half};
      end
      LSU_LOAD_HALF_WORD_U: begin
        data_o = {{(DATA_WIDTH-16){1'b0}}, sel_half};
      end
      LSU_LOAD_WORD: begin
        data_o = word_i;                  // Whole word, offset ignored
      end
      default: begin
        data_o = '0;                      // Stores never reach writeback
      end
    endcase
  end

endmodule : lsu_load_align

/* logic/lsu.sv */
/*
 * Load-store unit
 * Accepts one request at a time, drives the block RAM port and
 * sequences loads through IDLE, READ and CAPTURE to the writeback port
 */

module lsu (
  input  logic                clk_i,
  input  logic                rstn_i,

  // Decoder/ALU side
  input  logic                ctrl_valid_i,
  input  lsu_pkg::lsu_ctrl_t  ctrl_i,
  input  lsu_pkg::data_t      addr_i,       // Byte address
  input  lsu_pkg::data_t      wdata_i,      // Store data
  input  lsu_pkg::reg_addr_t  regdest_i,    // Load destination register
  output logic                ready_o,

  // Register file writeback
  output lsu_pkg::data_t      rdata_o,
  output logic                rf_wb_o,      // One-cycle write pulse
  output lsu_pkg::reg_addr_t  regdest_o,

  // Block RAM port
  output lsu_pkg::data_t      mem_addr_o,
  output lsu_pkg::byte_en_t   mem_we_o,
  output lsu_pkg::data_t      mem_wdata_o,
  input  lsu_pkg::data_t      mem_rdata_i
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,     // Free for a new request
    READ,     // RAM is reading the registered address
    CAPTURE   // RAM output valid, captured at the next edge
  } load_state_t;

  load_state_t state_q, state_d;

  logic        accept;      // Request taken this edge
  logic        is_store;
  byte_en_t    st_we;       // Enables from the store aligner
  data_t       st_wdata;    // Steered store data

  // Pending load, saved at acceptance
  lsu_ctrl_t   ld_ctrl_q;
  logic [1:0]  ld_off_q;
  reg_addr_t   ld_rd_q;

  // Completed load, held until the next one finishes
  lsu_ctrl_t   wb_ctrl_q;
  logic [1:0]  wb_off_q;
  data_t       word_q;

  assign ready_o  = (state_q == IDLE);
  assign accept   = ctrl_valid_i & ready_o;
  assign is_store = ctrl_i[LSU_CTRL_WIDTH-1];  // Top bit marks stores

  //////////////////////////////////////////////////
  // Store path
  //////////////////////////////////////////////////
  lsu_store_align u_store_align (
    .ctrl_i     (ctrl_i),
    .byte_off_i (addr_i[1:0]),
    .wdata_i    (wdata_i),
    .we_o       (st_we),
    .wdata_o    (st_wdata)
  );

  // Enables only live for one cycle after an accepted store
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mem_we_o <= '0;
    end else begin
      mem_we_o <= accept ? st_we : '0;
    end
  end

  // Address and data follow every accepted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_addr_o  <= addr_i;
      mem_wdata_o <= st_wdata;
    end
  end

  //////////////////////////////////////////////////
  // Load sequencing
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept && !is_store) state_d = READ;
      READ:    state_d = CAPTURE;  // RAM samples the address here
      CAPTURE: state_d = IDLE;     // Word captured, ready again
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= IDLE;
      rf_wb_o <= 1'b0;
    end else begin
      state_q <= state_d;
      rf_wb_o <= (state_q == CAPTURE);  // Pulse with the captured word
    end
  end

  // Remember what the load wants
  always_ff @(posedge clk_i) begin
    if (accept && !is_store) begin
      ld_ctrl_q <= ctrl_i;
      ld_off_q  <= addr_i[1:0];
      ld_rd_q   <= regdest_i;
    end
  end

  // Capture RAM word and hand the request over to writeback
  always_ff @(posedge clk_i) begin
    if (state_q == CAPTURE) begin
      word_q    <= mem_rdata_i;
      wb_ctrl_q <= ld_ctrl_q;
      wb_off_q  <= ld_off_q;
      regdest_o <= ld_rd_q;
    end
  end

  //////////////////////////////////////////////////
  // Load path
  //////////////////////////////////////////////////
  lsu_load_align u_load_align (
    .ctrl_i     (wb_ctrl_q),
    .byte_off_i (wb_off_q),
    .word_i     (word_q),
    .data_o     (rdata_o)
  );

endmodule : lsu

/* logic/data_ram.sv */
/*
 * Data RAM
 * Single-port word RAM with byte write enables and a registered
 * read, read register unchanged during writes (no-change mode)
 */

module data_ram #(
  parameter int RAM_DEPTH = 64              // Words, power of two
) (
  input  logic              clk_i,
  input  lsu_pkg::data_t    addr_i,         // Byte address
  input  lsu_pkg::byte_en_t we_i,           // Per-lane write enables
  input  lsu_pkg::data_t    wdata_i,
  output lsu_pkg::data_t    rdata_o         // One cycle after the address
);
  import lsu_pkg::*;

  localparam int IDX_WIDTH = $clog2(RAM_DEPTH);

  // Word index must cover the whole array exactly
  if ((1 << IDX_WIDTH) != RAM_DEPTH || RAM_DEPTH < 2) begin : g_depth_check
    $error("data_ram: RAM_DEPTH must be a power of two, at least 2");
  end

  data_t                mem [RAM_DEPTH];    // Storage, contents not reset
  logic [IDX_WIDTH-1:0] word_idx;

  // Drop byte offset, keep the bits the depth needs
  assign word_idx = addr_i[IDX_WIDTH+1:2];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    for (int lane = 0; lane < BYTE_LANES; lane++) begin
      if (we_i[lane]) begin
        mem[word_idx][8*lane +: 8] <= wdata_i[8*lane +: 8];
      end
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////
  // Output register holds its value on any write cycle
  always_ff @(posedge clk_i) begin
    if (we_i == '0) begin
      rdata_o <= mem[word_idx];
    end
  end

endmodule : data_ram

/* logic/lsu_top.sv */
/*
 * LSU top level
 * Load-store unit wired to its single-port data RAM
 */

module lsu_top #(
  parameter int RAM_DEPTH = 64                // Data RAM words
) (
  input  logic                clk_i,
  input  logic                rstn_i,

  // Decoder/ALU side
  input  logic                ctrl_valid_i,
  input  lsu_pkg::lsu_ctrl_t  ctrl_i,
  input  lsu_pkg::data_t      addr_i,
  input  lsu_pkg::data_t      wdata_i,
  input  lsu_pkg::reg_addr_t  regdest_i,
  output logic                ready_o,

  // Register file writeback
  output lsu_pkg::data_t      rdata_o,
  output logic                rf_wb_o,
  output lsu_pkg::reg_addr_t  regdest_o
);
  import lsu_pkg::*;

  // LSU to RAM
  data_t    mem_addr;
  byte_en_t mem_we;
  data_t    mem_wdata;
  data_t    mem_rdata;

  //////////////////////////////////////////////////
  // Load-store unit
  //////////////////////////////////////////////////
  lsu u_lsu (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .ctrl_valid_i (ctrl_valid_i),
    .ctrl_i       (ctrl_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .regdest_i    (regdest_i),
    .ready_o      (ready_o),
    .rdata_o      (rdata_o),
    .rf_wb_o      (rf_wb_o),
    .regdest_o    (regdest_o),
    .mem_addr_o   (mem_addr),
    .mem_we_o     (mem_we),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata)
  );

  //////////////////////////////////////////////////
  // Data RAM
  //////////////////////////////////////////////////
  data_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_data_ram (
    .clk_i   (clk_i),
    .addr_i  (mem_addr),
    .we_i    (mem_we),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule : lsu_top

/* verif/lsu_asserts.sv */
/*
 * LSU protocol checks
 * Concurrent assertions on the writeback pulse, the RAM byte enables
 * and load back-pressure, bound into the lsu module
 */

module lsu_asserts (
  input logic               clk_i,
  input logic               rstn_i,
  input logic               ctrl_valid_i,
  input lsu_pkg::lsu_ctrl_t ctrl_i,
  input logic               ready_i,     // lsu ready_o
  input logic               rf_wb_i,     // lsu rf_wb_o
  input lsu_pkg::byte_en_t  mem_we_i     // lsu mem_we_o
);
  import lsu_pkg::*;

  logic st_acc;  // Store taken this edge
  logic ld_acc;  // Load taken this edge

  assign st_acc = ctrl_valid_i & ready_i & ctrl_i[LSU_CTRL_WIDTH-1];
  assign ld_acc = ctrl_valid_i & ready_i & ~ctrl_i[LSU_CTRL_WIDTH-1];

  //////////////////////////////////////////////////
  // Writeback and RAM port
  //////////////////////////////////////////////////
  a_wb_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rf_wb_i |=> !rf_wb_i) else $error("rf_wb_o stayed high for two cycles");

  a_we_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (mem_we_i != '0) |-> $past(st_acc)) else $error("mem_we_o set without a store");

  a_we_store: assert property (@(posedge clk_i) disable iff (!rstn_i)
    st_acc |=> (mem_we_i != '0)) else $error("Accepted store left mem_we_o clear");

  //////////////////////////////////////////////////
  // Back-pressure
  //////////////////////////////////////////////////
  // READ and CAPTURE both hold ready low
  a_ready_load: assert property (@(posedge clk_i) disable iff (!rstn_i)
    ld_acc |=> !ready_i ##1 !ready_i ##1 ready_i) else $error("Load busy window wrong");

  a_ready_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !ready_i |-> ($past(ld_acc) || $past(ld_acc, 2))) else $error("ready_o low without a load");

endmodule : lsu_asserts

bind lsu lsu_asserts u_lsu_asserts (
  .clk_i        (clk_i),
  .rstn_i       (rstn_i),
  .ctrl_valid_i (ctrl_valid_i),
  .ctrl_i       (ctrl_i),
  .ready_i      (ready_o),
  .rf_wb_i      (rf_wb_o),
  .mem_we_i     (mem_we_o)
);

/* verif/lsu_tb.sv */
/*
 * LSU testbench
 * LFSR-driven loads and stores into lsu_top, checked against a
 * byte-array memory model on every writeback pulse
 */

module lsu_tb;
  import lsu_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_WORDS  = 64;
  localparam int MIX_OPS    = 400;
  // Reset, fill + readback, lane stores, sub-word loads, all-load worst case, drain slack
  localparam int WD_CYCLES  = 3 + 4*NUM_WORDS + 4*5 + 16*3 + 3*MIX_OPS + 50;

  logic clk_i, rstn_i, ctrl_valid_i, ready_o, rf_wb_o;
  lsu_ctrl_t ctrl_i;
  data_t     addr_i, wdata_i, rdata_o;
  reg_addr_t regdest_i, regdest_o;

  logic [15:0] lfsr = 16'd35;                 // Fixed seed
  logic [7:0]  model [256];                   // Byte image of the RAM
  data_t       exp_data[$];                   // Outstanding loads, oldest first
  reg_addr_t   exp_rd[$];
  time         exp_time[$];                   // Acceptance edge
  int errors = 0, checks = 0, loads = 0, wb_count = 0;

  lsu_top #(.RAM_DEPTH(NUM_WORDS)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic lsu_ctrl_t op_code(input int idx);
    case (idx)
      0: return LSU_LOAD_BYTE;
      1: return LSU_LOAD_BYTE_U;
      2: return LSU_LOAD_HALF_WORD;
      3: return LSU_LOAD_HALF_WORD_U;
      4: return LSU_LOAD_WORD;
      5: return LSU_STORE_BYTE;
      6: return LSU_STORE_HALF_WORD;
      default: return LSU_STORE_WORD;    // Indices 5..7 are stores
    endcase
  endfunction

  // Little-endian lanes, halfwords use bit 1 only
  function automatic data_t load_expect(input lsu_ctrl_t op, input logic [7:0] a);
    logic [7:0]  b;
    logic [15:0] h;
    b = model[a];
    h = {model[{a[7:1], 1'b1}], model[{a[7:1], 1'b0}]};
    case (op)
      LSU_LOAD_BYTE:        return {{24{b[7]}}, b};
      LSU_LOAD_BYTE_U:      return {24'd0, b};
      LSU_LOAD_HALF_WORD:   return {{16{h[15]}}, h};
      LSU_LOAD_HALF_WORD_U: return {16'd0, h};
      default: return {model[{a[7:2], 2'd3}], model[{a[7:2], 2'd2}],
                       model[{a[7:2], 2'd1}], model[{a[7:2], 2'd0}]};
    endcase
  endfunction

  function automatic void model_store(input lsu_ctrl_t op, input logic [7:0] a, input data_t d);
    case (op)
      LSU_STORE_BYTE: model[a] = d[7:0];
      LSU_STORE_HALF_WORD: begin
        model[{a[7:1], 1'b0}] = d[7:0];
        model[{a[7:1], 1'b1}] = d[15:8];
      end
      default: begin
        for (int k = 0; k < 4; k++) begin
          model[{a[7:2], k[1:0]}] = d[8*k +: 8];
        end
      end
    endcase
  endfunction

  // Drive on the falling edge, hold while the LSU is busy
  task automatic send(input lsu_ctrl_t op, input data_t a, input data_t d, input reg_addr_t rd);
    @(negedge clk_i);
    ctrl_valid_i = 1'b1;
    ctrl_i       = op;
    addr_i       = a;
    wdata_i      = d;
    regdest_i    = rd;
    while (ready_o !== 1'b1) @(negedge clk_i);
    @(posedge clk_i);                         // Accepting edge
    if (op[LSU_CTRL_WIDTH-1]) begin
      model_store(op, a[7:0], d);
    end else begin
      exp_data.push_back(load_expect(op, a[7:0]));
      exp_rd.push_back(rd);
      exp_time.push_back($time);
      loads++;
    end
  endtask

  task automatic drain();
    @(negedge clk_i);
    ctrl_valid_i = 1'b0;
    while (exp_data.size() != 0) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // Writeback checker, sampled mid-cycle
  //////////////////////////////////////////////////
  always @(negedge clk_i) begin
    if (rf_wb_o === 1'b1) begin
      wb_count++;
      assert (exp_data.size() != 0) else begin
        errors++;
        $display("Writeback pulse at %0t with no load outstanding", $time);
      end
      if (exp_data.size() != 0) begin
        checks++;
        // Pulse sits between edges 2 and 3 after acceptance
        assert (rdata_o === exp_data[0] && regdest_o === exp_rd[0] &&
                $time == exp_time[0] + 2*CLK_PERIOD + CLK_PERIOD/2) else begin
          errors++;
          $display("Error at %0t: got %h rd %0d, expected %h rd %0d (accepted %0t)",
                   $time, rdata_o, regdest_o, exp_data[0], exp_rd[0], exp_time[0]);
        end
        void'(exp_data.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_time.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [5:0] word;
    lsu_ctrl_t  op;
    data_t      addr;
    logic [7:0] last_addr;
    logic       last_store;
    ctrl_valid_i = 1'b0;
    ctrl_i       = LSU_LOAD_WORD;
    addr_i       = '0;
    wdata_i      = '0;
    regdest_i    = '0;
    rstn_i       = 1'b0;
    last_addr    = '0;
    last_store   = 1'b0;
    repeat (3) @(negedge clk_i);
    rstn_i = 1'b1;
    checks++;
    assert (ready_o === 1'b1 && rf_wb_o === 1'b0) else begin
      errors++;
      $display("Error at %0t: after reset ready_o=%b rf_wb_o=%b", $time, ready_o, rf_wb_o);
    end
    // Fill every word, then read all back
    for (int i = 0; i < NUM_WORDS; i++)
      send(LSU_STORE_WORD, data_t'(i*4), take_bits(32), '0);
    for (int i = 0; i < NUM_WORDS; i++)
      send(LSU_LOAD_WORD, data_t'(i*4), '0, reg_addr_t'(take_bits(5)));
    drain();
    // Byte and halfword lanes at each offset
    for (int off = 0; off < 4; off++) begin
      word = 6'(take_bits(6));
      send(LSU_STORE_BYTE, data_t'({word, off[1:0]}), take_bits(32), '0);
      send(LSU_STORE_HALF_WORD, data_t'({word, off[1:0]}), take_bits(32), '0);
      send(LSU_LOAD_WORD, data_t'({word, 2'b00}), '0, reg_addr_t'(take_bits(5)));
    end
    // Sub-word loads, every opcode at every offset
    for (int idx = 0; idx < 4; idx++) begin
      for (int off = 0; off < 4; off++) begin
        word = 6'(take_bits(6));
        send(op_code(idx), data_t'({word, off[1:0]}), '0, reg_addr_t'(take_bits(5)));
      end
    end
    drain();
    // Mixed stream
    for (int n = 0; n < MIX_OPS; n++) begin
      op   = op_code(int'(take_bits(3)));
      addr = take_bits(8);
      if (last_store) begin
        if (take_bits(1) == 1) begin
          op   = op_code(int'(take_bits(3)) % 5);   // Load of the word just stored
          addr = data_t'({last_addr[7:2], addr[1:0]});
        end
      end
      send(op, addr, take_bits(32), reg_addr_t'(take_bits(5)));
      last_store = op[LSU_CTRL_WIDTH-1];
      last_addr  = addr[7:0];
    end
    drain();
    repeat (4) @(negedge clk_i);              // Catch any late pulse
    checks++;
    assert (wb_count == loads) else begin
      errors++;
      $display("Error at %0t: %0d loads issued, %0d writebacks", $time, loads, wb_count);
    end
    $display("%0d checks, %0d errors, %0d loads, %0d writebacks",
             checks, errors, loads, wb_count);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("Timeout: sequence still running after %0d cycles", WD_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule : lsu_tb

/* lsu_top.f */
logic/lsu_pkg.sv
logic/lsu_store_align.sv
logic/lsu_load_align.sv
logic/lsu.sv
logic/data_ram.sv
logic/lsu_top.sv
verif/lsu_asserts.sv
verif/lsu_tb.sv
